// ==== decodeSubsys.f ====
uopPkg.sv
dispatchPkg.sv
uopQueue.sv
decodeFpu.sv
decodeUnits.sv
steerStage.sv
decodeTop.sv
decodeChecker.sv
tbDecode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbDecode
FILELIST ?= decodeSubsys.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== tbDecode.sv ====
// Testbench top for the decode slice with clock, reset, random traffic, back-pressure and a watchdog
`timescale 1ns/1ps

module tbDecode;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_UOPS = 400;
	localparam int STALL_START = 120;
	localparam int STALL_CYCLES = 40;
	// Six cycles of margin per micro-op plus the long stall and reset
	localparam int WATCHDOG_NS = (NUM_UOPS * 6 + STALL_CYCLES + RESET_CYCLES) * CLK_PERIOD;
	localparam logic [6:0] LEGAL_OPS [19] = '{
		uopPkg::NOP, uopPkg::ADD, uopPkg::ADDI, uopPkg::CMPI, uopPkg::ANDI, uopPkg::ORI,
		uopPkg::XORI, uopPkg::BRANCH, uopPkg::LOAD, uopPkg::STORE, uopPkg::FLTH, uopPkg::FLTS,
		uopPkg::FLTD, uopPkg::FLTQ, uopPkg::FLTPH, uopPkg::FLTPS, uopPkg::FLTPD, uopPkg::FLTPQ,
		uopPkg::FLTP
	};

	logic clk = 1'b0;
	logic rst;
	logic inValid;
	logic inReady;
	uopPkg::tagged_uop_t inUop;
	logic outValid;
	logic outReady;
	dispatchPkg::decoded_uop_t outDecoded;
	logic endOfTest;
	int mismatches;
	int failures;
	int sent;
	int received;
	int cycle;

	always #(CLK_PERIOD / 2) clk = ~clk;

	decodeTop dut0 (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inUop(inUop),
		.outValid(outValid),
		.outReady(outReady),
		.outDecoded(outDecoded)
	);

	decodeChecker chk0 (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inUop(inUop),
		.outValid(outValid),
		.outReady(outReady),
		.outDecoded(outDecoded),
		.endOfTest(endOfTest),
		.mismatches(mismatches),
		.failures(failures)
	);

	// Roughly one in seven micro-ops carries a random, mostly illegal, opcode
	function automatic uopPkg::tagged_uop_t randomUop(input int index);
		uopPkg::tagged_uop_t u;
		logic [31:0] bits;
		logic [6:0] op;
		bits = $urandom();
		if ($urandom_range(99) < 15)
			op = 7'($urandom_range(127));
		else
			op = LEGAL_OPS[5'($urandom_range(18))];
		u.tag = 8'(index);
		u.uop = {op, bits[24:0]};
		return u;
	endfunction

	// Counts output transfers and picks outReady, with one long stall window
	task automatic stepOutput();
		cycle++;
		if (outValid && outReady)
			received++;
		if (cycle >= STALL_START && cycle < STALL_START + STALL_CYCLES)
			outReady <= 1'b0;
		else
			outReady <= ($urandom_range(99) < 60);
	endtask

	initial
	begin
		void'($urandom(32'h2107_0e31));
		rst = 1'b1;
		inValid = 1'b0;
		inUop = '0;
		outReady = 1'b0;
		endOfTest = 1'b0;
		sent = 0;
		received = 0;
		cycle = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		while (received < NUM_UOPS)
		begin
			@(posedge clk);
			if (inValid && inReady)
				sent++;
			stepOutput();
			// A stalled micro-op stays on the bus until it is taken
			if (!inValid || inReady)
			begin
				if (sent < NUM_UOPS && $urandom_range(99) < 70)
				begin
					inValid <= 1'b1;
					inUop <= randomUop(sent);
				end
				else
					inValid <= 1'b0;
			end
		end
		repeat (2) @(posedge clk);
		endOfTest <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		$display("Errors: mismatches=%0d other=%0d timeouts=0", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// ========================================================================
	// Watchdog
	// ========================================================================

	initial
	begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired with %0d of %0d micro-ops emitted", received, NUM_UOPS);
		$display("Errors: mismatches=%0d other=%0d timeouts=1", mismatches, failures);
		$display("sim failed");
		$finish;
	end

endmodule

// ==== decodeChecker.sv ====
// Watches both handshakes of the decode slice, predicts every record and counts the errors it finds
`timescale 1ns/1ps

module decodeChecker (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	input  logic inReady,
	input  uopPkg::tagged_uop_t inUop,
	input  logic outValid,
	input  logic outReady,
	input  dispatchPkg::decoded_uop_t outDecoded,
	input  logic endOfTest,
	output int mismatches,
	output int failures
);

	// Records accepted at the input and not yet seen at the output, oldest first
	dispatchPkg::decoded_uop_t expQ [$];
	int mismatchCount = 0;
	int failureCount = 0;
	// Shared ALU/FPU toggle; acceptance order equals output order, so it can run at the input
	logic altFpu = 1'b0;
	logic sawFull = 1'b0;
	logic finalDone = 1'b0;

	assign mismatches = mismatchCount;
	assign failures = failureCount;

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic dispatchPkg::decoded_uop_t expectDecode(input uopPkg::tagged_uop_t u,
		input logic pickFpu);
		dispatchPkg::decoded_uop_t e;
		logic [31:0] w;
		logic [6:0] op;
		logic isFp;
		logic isImmAlu;
		w = u.uop;
		op = w[31:25];
		e = '0;
		isFp = 1'b0;
		isImmAlu = 1'b0;
		case (op)
			uopPkg::FLTH, uopPkg::FLTS, uopPkg::FLTD, uopPkg::FLTQ, uopPkg::FLTPH,
			uopPkg::FLTPS, uopPkg::FLTPD, uopPkg::FLTPQ, uopPkg::FLTP:
				isFp = 1'b1;
			uopPkg::ADDI, uopPkg::CMPI, uopPkg::ANDI, uopPkg::ORI, uopPkg::XORI:
				isImmAlu = 1'b1;
			default:
				isFp = 1'b0;
		endcase
		e.tag = u.tag;
		e.unitMask.alu = isImmAlu || op == uopPkg::ADD || op == uopPkg::NOP;
		// NOP is accepted anywhere, immediates go to the FPU only with the sharing switch on
		e.unitMask.fpu = isFp || op == uopPkg::NOP || (isImmAlu && dispatchPkg::PERFORMANCE);
		e.unitMask.mem = op == uopPkg::LOAD || op == uopPkg::STORE;
		e.unitMask.branch = op == uopPkg::BRANCH;
		e.hasImm = isImmAlu || e.unitMask.mem || e.unitMask.branch;
		e.rd = w[24:20];
		e.rs1 = w[19:15];
		if (e.hasImm)
			e.imm = w[14:0];
		else
			e.rs2 = w[14:10];
		if (e.unitMask.alu && e.unitMask.fpu)
			e.target = pickFpu ? dispatchPkg::FPU : dispatchPkg::ALU;
		else if (e.unitMask.alu)
			e.target = dispatchPkg::ALU;
		else if (e.unitMask.fpu)
			e.target = dispatchPkg::FPU;
		else if (e.unitMask.mem)
			e.target = dispatchPkg::MEM;
		else if (e.unitMask.branch)
			e.target = dispatchPkg::BRANCH;
		else
			e.target = dispatchPkg::NONE;
		return e;
	endfunction

	task automatic checkField(input string name, input logic [7:0] tag, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act)
		begin
			mismatchCount++;
			$display("MISMATCH test=%s tag=%0d expected=0x%0h actual=0x%0h", name, tag, exp, act);
		end
	endtask

	// ========================================================================
	// Handshake monitor
	// ========================================================================

	always @(posedge clk)
	begin
		dispatchPkg::decoded_uop_t exp;
		if (rst)
		begin
			if (outValid === 1'b1 || inReady === 1'b1)
			begin
				failureCount++;
				$display("ERROR: outValid or inReady is high during reset");
			end
			altFpu = 1'b0;
		end
		else
		begin
			// Queue holds two and the steering register one, so three outstanding means full
			if (expQ.size() == 3 && inReady)
			begin
				failureCount++;
				$display("ERROR: inReady is high while the queue is full");
			end
			if (expQ.size() == 3 && !inReady)
				sawFull = 1'b1;
			if (outValid && expQ.size() == 0)
			begin
				failureCount++;
				$display("ERROR: outValid is high with no accepted micro-op outstanding");
			end
			else if (outValid && outReady)
			begin
				exp = expQ.pop_front();
				checkField("tag", exp.tag, 32'(exp.tag), 32'(outDecoded.tag));
				checkField("unitMask", exp.tag, 32'(exp.unitMask), 32'(outDecoded.unitMask));
				checkField("target", exp.tag, 32'(exp.target), 32'(outDecoded.target));
				checkField("hasImm", exp.tag, 32'(exp.hasImm), 32'(outDecoded.hasImm));
				checkField("rd", exp.tag, 32'(exp.rd), 32'(outDecoded.rd));
				checkField("rs1", exp.tag, 32'(exp.rs1), 32'(outDecoded.rs1));
				checkField("rs2", exp.tag, 32'(exp.rs2), 32'(outDecoded.rs2));
				checkField("imm", exp.tag, 32'(exp.imm), 32'(outDecoded.imm));
			end
			if (inValid && inReady)
			begin
				exp = expectDecode(inUop, altFpu);
				expQ.push_back(exp);
				if (exp.unitMask.alu && exp.unitMask.fpu)
					altFpu = ~altFpu;
			end
			if (endOfTest && !finalDone)
			begin
				finalDone = 1'b1;
				if (expQ.size() != 0)
				begin
					failureCount++;
					$display("ERROR: %0d accepted micro-ops never came out", expQ.size());
				end
				if (!sawFull)
				begin
					failureCount++;
					$display("ERROR: the queue never filled, so back-pressure went untested");
				end
			end
		end
	end

endmodule

// ==== decodeTop.sv ====
// Top of the decode classification slice wiring input queue, unit decoder and steering register
`timescale 1ns/1ps

module decodeTop (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	output logic inReady,
	input  uopPkg::tagged_uop_t inUop,
	output logic outValid,
	input  logic outReady,
	output dispatchPkg::decoded_uop_t outDecoded
);

	// Queue head and its handshake
	logic qValid;
	logic qReady;
	uopPkg::tagged_uop_t qUop;
	// Decoder output before a target is chosen
	dispatchPkg::decoded_uop_t decoded;

	uopQueue queue0 (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inUop(inUop),
		.qValid(qValid),
		.qReady(qReady),
		.qUop(qUop)
	);

	// Purely combinational, so the queue head is classified in the same cycle
	decodeUnits units0 (
		.qUop(qUop),
		.decoded(decoded)
	);

	steerStage steer0 (
		.clk(clk),
		.rst(rst),
		.qValid(qValid),
		.qReady(qReady),
		.decoded(decoded),
		.outValid(outValid),
		.outReady(outReady),
		.outDecoded(outDecoded)
	);

endmodule

// ==== steerStage.sv ====
// Output register that picks the target unit, alternates shared ALU/FPU work and applies back-pressure
`timescale 1ns/1ps

module steerStage (
	input  logic clk,
	input  logic rst,
	input  logic qValid,
	output logic qReady,
	input  dispatchPkg::decoded_uop_t decoded,
	output logic outValid,
	input  logic outReady,
	output dispatchPkg::decoded_uop_t outDecoded
);

	logic load;
	logic shared;
	// Low means the next shared micro-op goes to the ALU
	logic pickFpu;
	dispatchPkg::unit_e target;

	// Take a new record when empty or when the current one leaves this cycle
	assign qReady = !outValid || outReady;
	assign load = qValid && qReady;

	// Both ALU and FPU can take it, so the load balancer decides
	assign shared = decoded.unitMask.alu && decoded.unitMask.fpu;

	always_comb
	begin
		if (shared)
			target = pickFpu ? dispatchPkg::FPU : dispatchPkg::ALU;
		else if (decoded.unitMask.alu)
			target = dispatchPkg::ALU;
		else if (decoded.unitMask.fpu)
			target = dispatchPkg::FPU;
		else if (decoded.unitMask.mem)
			target = dispatchPkg::MEM;
		else if (decoded.unitMask.branch)
			target = dispatchPkg::BRANCH;
		else
			target = dispatchPkg::NONE;
	end

	// ========================================================================
	// Control state
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			outValid <= 1'b0;
			pickFpu <= 1'b0;
		end
		else
		begin
			if (load)
				outValid <= 1'b1;
			else if (outReady)
				outValid <= 1'b0;
			// Single-unit micro-ops leave the alternation alone
			if (load && shared)
				pickFpu <= ~pickFpu;
		end
	end

	// Payload register
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			outDecoded <= decoded;
			outDecoded.target <= target;
		end
	end

endmodule

// ==== decodeUnits.sv ====
// Combinational unit-mask and operand-field decoder placed between the input queue and steering
`timescale 1ns/1ps

module decodeUnits (
	input  uopPkg::tagged_uop_t qUop,
	output dispatchPkg::decoded_uop_t decoded
);

	uopPkg::micro_op_t uop;
	uopPkg::opcode_e opcode;
	logic fpuOk;
	logic aluOk;
	logic memOk;
	logic branchOk;
	logic hasImm;

	assign uop = qUop.uop;
	assign opcode = uop.any.opcode;

	// ========================================================================
	// Unit classification
	// ========================================================================

	// The FPU decision lives in one place only
	decodeFpu fpuDec (
		.uop(uop),
		.fpu(fpuOk)
	);

	// Integer and memory classes; floating-point opcodes fall to the default
	always_comb
	begin
		aluOk = 1'b0;
		memOk = 1'b0;
		branchOk = 1'b0;
		hasImm = 1'b0;
		case (opcode)
			uopPkg::ADD:
				aluOk = 1'b1;
			uopPkg::ADDI,
			uopPkg::CMPI,
			uopPkg::ANDI,
			uopPkg::ORI,
			uopPkg::XORI:
			begin
				aluOk = 1'b1;
				hasImm = 1'b1;
			end
			uopPkg::NOP:
				aluOk = 1'b1;
			uopPkg::LOAD,
			uopPkg::STORE:
			begin
				memOk = 1'b1;
				// Address offset rides in the immediate field
				hasImm = 1'b1;
			end
			uopPkg::BRANCH:
			begin
				branchOk = 1'b1;
				// Displacement rides in the immediate field
				hasImm = 1'b1;
			end
			default:
			begin
				aluOk = 1'b0;
				hasImm = 1'b0;
			end
		endcase
	end

	// ========================================================================
	// Record assembly
	// ========================================================================

	always_comb
	begin
		decoded.tag = qUop.tag;
		decoded.unitMask.alu = aluOk;
		decoded.unitMask.fpu = fpuOk;
		decoded.unitMask.mem = memOk;
		decoded.unitMask.branch = branchOk;
		// Steering picks the real target later
		decoded.target = dispatchPkg::NONE;
		decoded.hasImm = hasImm;
		// rd and rs1 sit at the same bits in both formats
		decoded.rd = uop.rr.rd;
		decoded.rs1 = uop.rr.rs1;
		// The field that the format does not carry is forced to zero
		if (hasImm)
		begin
			decoded.rs2 = '0;
			decoded.imm = uop.ri.imm;
		end
		else
		begin
			decoded.rs2 = uop.rr.rs2;
			decoded.imm = '0;
		end
	end

endmodule

// ==== decodeFpu.sv ====
// Combinational check of whether a micro-op may be issued to the floating-point unit
`timescale 1ns/1ps

module decodeFpu (
	input  uopPkg::micro_op_t uop,
	output logic fpu
);

	// Only the opcode matters here, so the opaque view is enough
	always_comb
	begin
		case (uop.any.opcode)
			// All floating-point formats, scalar and packed
			uopPkg::FLTH,
			uopPkg::FLTS,
			uopPkg::FLTD,
			uopPkg::FLTQ,
			uopPkg::FLTPH,
			uopPkg::FLTPS,
			uopPkg::FLTPD,
			uopPkg::FLTPQ,
			uopPkg::FLTP:
				fpu = 1'b1;
			// Simple immediate operations are shared with the FPU integer path
			// only when the package switch asks for it
			uopPkg::ADDI,
			uopPkg::CMPI,
			uopPkg::ANDI,
			uopPkg::ORI,
			uopPkg::XORI:
				fpu = dispatchPkg::PERFORMANCE;
			// Any unit can retire a NOP
			uopPkg::NOP:
				fpu = 1'b1;
			default:
				fpu = 1'b0;
		endcase
	end

endmodule

// ==== uopQueue.sv ====
// Two-entry input skid queue that accepts tagged micro-ops over valid/ready and feeds the decoder
`timescale 1ns/1ps

module uopQueue (
	input  logic clk,
	input  logic rst,
	input  logic inValid,
	output logic inReady,
	input  uopPkg::tagged_uop_t inUop,
	output logic qValid,
	input  logic qReady,
	output uopPkg::tagged_uop_t qUop
);

	// Two payload slots, written at wrPtr and read at rdPtr
	uopPkg::tagged_uop_t entries [2];
	logic wrPtr;
	logic rdPtr;
	logic [1:0] count;
	logic [1:0] countNext;
	logic push;
	logic pop;

	// inReady is a register, so a push never depends on downstream ready
	assign push = inValid && inReady;
	assign pop = qValid && qReady;

	// Head of queue goes straight to the decoder
	assign qValid = (count != 2'd0);
	assign qUop = entries[rdPtr];

	always_comb
	begin
		countNext = count;
		case ({push, pop})
			2'b10: countNext = count + 2'd1;
			2'b01: countNext = count - 2'd1;
			default: countNext = count;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (push)
			entries[wrPtr] <= inUop;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= 1'b0;
			rdPtr <= 1'b0;
			count <= 2'd0;
			inReady <= 1'b0;
		end
		else
		begin
			if (push)
				wrPtr <= ~wrPtr;
			if (pop)
				rdPtr <= ~rdPtr;
			count <= countNext;
			// Look ahead one cycle so ready drops as the second slot fills
			inReady <= (countNext != 2'd2);
		end
	end

endmodule

// ==== dispatchPkg.sv ====
// Dispatch-side definitions (unit codes, unit mask, decoded record, FPU sharing switch) for decode
package dispatchPkg;

	// ========================================================================
	// Functional units
	// ========================================================================

	// Target unit code; NONE marks an illegal micro-op
	typedef enum logic [2:0] {
		NONE   = 3'd0,
		ALU    = 3'd1,
		FPU    = 3'd2,
		MEM    = 3'd3,
		BRANCH = 3'd4
	} unit_e;

	// One bit per unit that is able to execute the micro-op
	typedef struct packed {
		logic alu;
		logic fpu;
		logic mem;
		logic branch;
	} unit_mask_t;

	// When set, the FPU also accepts the simple immediate ALU operations
	localparam logic PERFORMANCE = 1'b1;

	// ========================================================================
	// Decoded record
	// ========================================================================

	// Output handshake payload
	// rs2 is zero for immediate formats and imm is zero for register formats
	typedef struct packed {
		logic [uopPkg::TAG_W-1:0] tag;
		unit_mask_t unitMask;
		unit_e target;
		logic hasImm;
		logic [uopPkg::REG_W-1:0] rd;
		logic [uopPkg::REG_W-1:0] rs1;
		logic [uopPkg::REG_W-1:0] rs2;
		logic [uopPkg::IMM_W-1:0] imm;
	} decoded_uop_t;

endpackage

// ==== uopPkg.sv ====
// Instruction-side definitions (opcodes, micro-op word views, field widths) used by the decode slice
package uopPkg;

	// ========================================================================
	// Field widths
	// ========================================================================

	localparam int OPCODE_W = 7;
	localparam int REG_W = 5;
	localparam int FUNC_W = 10;
	localparam int IMM_W = 15;
	localparam int TAG_W = 8;

	// Everything after the opcode, seen as one opaque field
	localparam int REST_W = 32 - OPCODE_W;

	// ========================================================================
	// Opcodes
	// ========================================================================

	// Seven-bit opcode space; any encoding not listed here is illegal
	typedef enum logic [OPCODE_W-1:0] {
		NOP    = 7'h00,
		ADD    = 7'h02,
		ADDI   = 7'h04,
		CMPI   = 7'h05,
		ANDI   = 7'h08,
		ORI    = 7'h09,
		XORI   = 7'h0a,
		BRANCH = 7'h28,
		LOAD   = 7'h48,
		STORE  = 7'h49,
		// Scalar floating point, half through quad precision
		FLTH   = 7'h70,
		FLTS   = 7'h71,
		FLTD   = 7'h72,
		FLTQ   = 7'h73,
		// Packed floating point, half through quad precision
		FLTPH  = 7'h74,
		FLTPS  = 7'h75,
		FLTPD  = 7'h76,
		FLTPQ  = 7'h77,
		// Generic packed operation, precision carried in func
		FLTP   = 7'h78
	} opcode_e;

	// ========================================================================
	// Micro-op word
	// ========================================================================

	// The same 32 bits read three ways; the opcode always sits at the top
	typedef union packed {
		struct packed {
			opcode_e opcode;
			logic [REST_W-1:0] rest;
		} any;
		struct packed {
			opcode_e opcode;
			logic [REG_W-1:0] rd;
			logic [REG_W-1:0] rs1;
			logic [REG_W-1:0] rs2;
			logic [FUNC_W-1:0] func;
		} rr;
		struct packed {
			opcode_e opcode;
			logic [REG_W-1:0] rd;
			logic [REG_W-1:0] rs1;
			logic [IMM_W-1:0] imm;
		} ri;
	} micro_op_t;

	// Input handshake payload: the micro-op plus its program-order tag
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		micro_op_t uop;
	} tagged_uop_t;

endpackage
